/* verilog/pktbuf_pkg.sv */
package pktbuf_pkg;

	// packet word and its split over the memory channels
	localparam int WORD_W   = 520;  // one packet word
	localparam int CHAN_W   = 72;   // one memory channel, data plus spare bits
	localparam int NUM_CHAN = 8;    // channels per word, last one only partly used

	// host command
	typedef enum logic {
		op_write = 1'b0,  // store wdata at addr
		op_read  = 1'b1   // fetch the word at addr
	} op_e;

	// decode FSM
	typedef enum logic [1:0] {
		st_idle  = 2'd0,  // waiting for req
		st_issue = 2'd1,  // fire the access strobe
		st_hold  = 2'd2   // wait for req to drop
	} dec_state_e;

endpackage

/* verilog/pktbuf_access_if.sv */
`timescale 1ns/1ps

interface pktbuf_access_if #(
	parameter int AWIDTH = 6
);
	import pktbuf_pkg::*;

	logic              wren;       // one-cycle write strobe
	logic              rden;       // one-cycle read strobe
	logic [AWIDTH-1:0] wraddress;  // write port address
	logic [AWIDTH-1:0] rdaddress;  // read port address
	logic [WORD_W-1:0] wrdata;     // full packet word

	modport issuer (  // decode side
		output wren, rden, wraddress, rdaddress, wrdata
	);

	modport memory (  // memory side
		input wren, rden, wraddress, rdaddress, wrdata
	);

endinterface

/* verilog/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode #(
	parameter int AWIDTH = 6
) (
	input  logic                          clk_esram,
	input  logic                          arst_n,
	input  logic                          req,
	input  pktbuf_pkg::op_e               op,
	input  logic [AWIDTH-1:0]             addr,
	input  logic [pktbuf_pkg::WORD_W-1:0] wdata,
	pktbuf_access_if.issuer               acc,
	output logic                          wr_done
);
	import pktbuf_pkg::*;

	dec_state_e        state;    // handshake position
	op_e               op_q;     // latched opcode
	logic [AWIDTH-1:0] addr_q;   // latched address
	logic [WORD_W-1:0] wdata_q;  // latched packet word
	logic              wren_q;   // registered write strobe
	logic              rden_q;   // registered read strobe

	// command capture, only once per handshake
	always_ff @(posedge clk_esram) begin
		if (state == st_idle && req) begin
			op_q    <= op;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
	end

	always_ff @(posedge clk_esram or negedge arst_n) begin
		if (!arst_n) begin
			state   <= st_idle;
			wren_q  <= 1'b0;
			rden_q  <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			wren_q  <= 1'b0;  // strobes are single pulses
			rden_q  <= 1'b0;
			wr_done <= 1'b0;
			case (state)
				st_idle: begin
					if (req) state <= st_issue;  // command sampled at this edge
				end
				st_issue: begin
					wren_q  <= (op_q == op_write);
					rden_q  <= (op_q == op_read);
					wr_done <= (op_q == op_write);  // write needs no read-back
					state   <= st_hold;
				end
				st_hold: begin
					if (!req) state <= st_idle;  // held req issues nothing more
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign acc.wren      = wren_q;
	assign acc.rden      = rden_q;
	assign acc.wraddress = addr_q;  // both ports see the same address
	assign acc.rdaddress = addr_q;
	assign acc.wrdata    = wdata_q;

	// one access type per cycle into the memory
	a_one_strobe: assert property (@(posedge clk_esram) disable iff (!arst_n)
		!(acc.wren && acc.rden))
		else $error("decode: wren and rden high together");

endmodule

/* verilog/esram_channel.sv */
`timescale 1ns/1ps

module esram_channel #(
	parameter int AWIDTH = 6
) (
	input  logic                          clk_esram,
	input  logic                          wren,
	input  logic [AWIDTH-1:0]             wraddress,
	input  logic [pktbuf_pkg::CHAN_W-1:0] wrdata,
	input  logic                          rden,
	input  logic [AWIDTH-1:0]             rdaddress,
	output logic [pktbuf_pkg::CHAN_W-1:0] q
);
	import pktbuf_pkg::*;

	localparam int DEPTH = 2 ** AWIDTH;  // words per channel

	logic [CHAN_W-1:0] mem [DEPTH];  // channel storage, contents not reset

	// port a, write
	always_ff @(posedge clk_esram) begin
		if (wren) begin
			mem[wraddress] <= wrdata;
		end
	end

	// port b, registered read
	always_ff @(posedge clk_esram) begin
		if (rden) begin
			q <= mem[rdaddress];  // holds until the next read
		end
	end

endmodule

/* verilog/esram_wrapper.sv */
`timescale 1ns/1ps

module esram_wrapper #(
	parameter int AWIDTH       = 6,
	parameter int READ_LATENCY = 12
) (
	input  logic                          clk_esram,
	input  logic                          arst_n,
	pktbuf_access_if.memory               acc,
	output logic                          rd_valid,
	output logic [pktbuf_pkg::WORD_W-1:0] rddata
);
	import pktbuf_pkg::*;

	localparam int TOP_W = WORD_W - (NUM_CHAN - 1) * CHAN_W;  // 16 bits in the last channel
	localparam int PAD_W = CHAN_W - TOP_W;                   // unused top of the last channel

	logic [CHAN_W-1:0]       chan_wdata [NUM_CHAN];  // per channel write slice
	logic [CHAN_W-1:0]       chan_q     [NUM_CHAN];  // per channel read data
	logic [READ_LATENCY-1:0] rden_pipe;             // read strobe delay line

	if (READ_LATENCY < 2) begin : g_bad_latency
		$error("esram_wrapper: READ_LATENCY must be at least 2");
	end

	for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
		if (i < NUM_CHAN - 1) begin : g_full
			assign chan_wdata[i]              = acc.wrdata[i*CHAN_W +: CHAN_W];
			assign rddata[i*CHAN_W +: CHAN_W] = chan_q[i];
		end else begin : g_top
			assign chan_wdata[i]            = {{PAD_W{1'b0}}, acc.wrdata[WORD_W-1 -: TOP_W]};
			assign rddata[WORD_W-1 -: TOP_W] = chan_q[i][TOP_W-1:0];  // drop the padding
		end

		esram_channel #(
			.AWIDTH (AWIDTH)
		) u_chan (
			.clk_esram (clk_esram),
			.wren      (acc.wren),       // all channels written together
			.wraddress (acc.wraddress),
			.wrdata    (chan_wdata[i]),
			.rden      (acc.rden),
			.rdaddress (acc.rdaddress),
			.q         (chan_q[i])
		);
	end

	// fixed read latency, channel outputs stay put until the next read strobe
	always_ff @(posedge clk_esram or negedge arst_n) begin
		if (!arst_n) begin
			rden_pipe <= '0;
		end else begin
			rden_pipe <= {rden_pipe[READ_LATENCY-2:0], acc.rden};  // may hold several reads
		end
	end

	assign rd_valid = rden_pipe[READ_LATENCY-1];

	// every read strobe comes back as rd_valid after the full pipe
	a_rd_latency: assert property (@(posedge clk_esram) disable iff (!arst_n)
		acc.rden |-> ##READ_LATENCY rd_valid)
		else $error("wrapper: rd_valid missing %0d cycles after rden", READ_LATENCY);

	// padding goes in as zero so it must come back as zero
	a_top_pad: assert property (@(posedge clk_esram) disable iff (!arst_n)
		rd_valid |-> chan_q[NUM_CHAN-1][CHAN_W-1:TOP_W] == '0)
		else $error("wrapper: channel %0d padding not zero", NUM_CHAN - 1);

endmodule

/* verilog/rd_result.sv */
`timescale 1ns/1ps

module rd_result (
	input  logic                          clk_esram,
	input  logic                          arst_n,
	input  logic                          req,
	input  logic                          wr_done,
	input  logic                          rd_valid,
	input  logic [pktbuf_pkg::WORD_W-1:0] rddata,
	output logic                          ack,
	output logic [pktbuf_pkg::WORD_W-1:0] rdata
);

	// read data capture, held while ack is up and beyond
	always_ff @(posedge clk_esram) begin
		if (rd_valid) begin
			rdata <= rddata;
		end
	end

	// ack goes up when the access is done, down once the host lets go of req
	always_ff @(posedge clk_esram or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
		end else if (wr_done || rd_valid) begin
			ack <= 1'b1;  // same edge as the rdata capture
		end else if (!req) begin
			ack <= 1'b0;
		end
	end

	// a completion during ack means decode issued a second access in one handshake
	a_no_early_done: assert property (@(posedge clk_esram) disable iff (!arst_n)
		(wr_done || rd_valid) |-> !ack)
		else $error("result: completion while ack already high");

endmodule

/* verilog/pktbuf_top.sv */
`timescale 1ns/1ps

module pktbuf_top #(
	parameter int AWIDTH       = 6,   // 64 packet words
	parameter int READ_LATENCY = 12   // strobe to rd_valid, at least 2
) (
	input  logic                          clk_esram,
	input  logic                          arst_n,
	input  logic                          req,
	input  pktbuf_pkg::op_e               op,
	input  logic [AWIDTH-1:0]             addr,
	input  logic [pktbuf_pkg::WORD_W-1:0] wdata,
	output logic                          ack,
	output logic [pktbuf_pkg::WORD_W-1:0] rdata
);
	import pktbuf_pkg::*;

	logic              wr_done;   // write finished pulse
	logic              rd_valid;  // read data valid pulse
	logic [WORD_W-1:0] rddata;    // reassembled read word

	pktbuf_access_if #(
		.AWIDTH (AWIDTH)
	) acc_if ();

	cmd_decode #(
		.AWIDTH (AWIDTH)
	) u_cmd_decode (
		.clk_esram (clk_esram),
		.arst_n    (arst_n),
		.req       (req),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.acc       (acc_if.issuer),
		.wr_done   (wr_done)
	);

	esram_wrapper #(
		.AWIDTH       (AWIDTH),
		.READ_LATENCY (READ_LATENCY)
	) u_esram_wrapper (
		.clk_esram (clk_esram),
		.arst_n    (arst_n),
		.acc       (acc_if.memory),
		.rd_valid  (rd_valid),
		.rddata    (rddata)
	);

	rd_result u_rd_result (
		.clk_esram (clk_esram),
		.arst_n    (arst_n),
		.req       (req),
		.wr_done   (wr_done),
		.rd_valid  (rd_valid),
		.rddata    (rddata),
		.ack       (ack),
		.rdata     (rdata)
	);

endmodule

/* bench/tb_pktbuf.sv */
`timescale 1ns/1ps

module tb_pktbuf;
	import pktbuf_pkg::*;

	localparam int AWIDTH       = 6;        // 64 packet words
	localparam int READ_LATENCY = 12;       // strobe to rd_valid
	localparam int NUM_CMDS     = 200;      // long random run
	localparam int TIMEOUT      = 200;      // falling edges allowed per wait
	localparam int SEED         = 32'hac26;

	logic              clk_esram;
	logic              arst_n;
	logic              req;
	op_e               op;
	logic [AWIDTH-1:0] addr;
	logic [WORD_W-1:0] wdata;
	logic              ack;
	logic [WORD_W-1:0] rdata;

	logic [WORD_W-1:0] model [int];   // reference memory, written words by address
	int                addr_list[$];  // addresses the model holds
	int                err_data;      // wrong read words
	int                err_hs;        // handshake level or edge count wrong
	int                err_timeout;   // waits that ran out
	bit                hung;          // a wait ran out, issue nothing more

	pktbuf_top #(
		.AWIDTH       (AWIDTH),
		.READ_LATENCY (READ_LATENCY)
	) u_pktbuf_top (
		.clk_esram (clk_esram),
		.arst_n    (arst_n),
		.req       (req),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.ack       (ack),
		.rdata     (rdata)
	);

	always #2 clk_esram = ~clk_esram;  // 4 ns period

	task automatic check_word(input logic [WORD_W-1:0] exp, input logic [WORD_W-1:0] act,
			input string what);
		if (act !== exp) begin
			err_data++;
			$display("ERR %0t: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_ack(input logic exp, input logic act, input string what);
		if (act !== exp) begin
			err_hs++;
			$display("ERR %0t: %s expected ack %b got %b", $time, what, exp, act);
		end
	endtask

	task automatic check_edges(input int exp, input int act, input string what);
		if (act != exp) begin
			err_hs++;
			$display("ERR %0t: %s expected %0d edges got %0d", $time, what, exp, act);
		end
	endtask

	// 17 draws of 32 bits cover all 520, top slice included
	function automatic logic [WORD_W-1:0] rand_word();
		logic [WORD_W-1:0] w;
		int                i;
		w = '0;
		for (i = 0; i < 17; i++) begin
			w = {w[WORD_W-33:0], $urandom()};
		end
		return w;
	endfunction

	// n counts falling edges until ack reaches level
	task automatic wait_ack(input logic level, output int n);
		n = 0;
		do begin
			@(negedge clk_esram);
			n++;
		end while (ack !== level && n < TIMEOUT);
		if (ack !== level) begin
			err_timeout++;
			hung = 1'b1;
			$display("timeout at %0t: ack did not go %s within %0d cycles",
				$time, level ? "high" : "low", TIMEOUT);
		end
	endtask

	// one full four-phase handshake, called at a falling edge
	task automatic run_cmd(input op_e c_op, input logic [AWIDTH-1:0] c_addr,
			input logic [WORD_W-1:0] c_data);
		int n;
		int hold;
		int a;
		if (hung) return;
		a     = int'(c_addr);
		op    = c_op;
		addr  = c_addr;
		wdata = c_data;
		req   = 1'b1;
		wait_ack(1'b1, n);  // first rising edge after this is edge 0
		if (hung) return;
		if (c_op == op_write) begin
			check_edges(2, n - 1, "write ack rise");
			if (!model.exists(a)) addr_list.push_back(a);
			model[a] = c_data;  // later writes overwrite
		end else begin
			check_edges(READ_LATENCY + 2, n - 1, "read ack rise");
			check_word(model[a], rdata, $sformatf("read addr %0d", a));
		end
		hold = $urandom_range(0, 4);  // extra cycles with req still high
		if (hold > 0) begin
			op    = op_write;  // a second latch would store this word at addr
			wdata = ~c_data;
		end
		repeat (hold) begin
			@(negedge clk_esram);
			check_ack(1'b1, ack, "ack while req held");
		end
		req = 1'b0;
		wait_ack(1'b0, n);
		if (hung) return;
		check_edges(1, n, "ack fall");
		op    = ($urandom_range(0, 1) == 0) ? op_write : op_read;  // junk while req low
		addr  = AWIDTH'($urandom_range(0, 2**AWIDTH - 1));
		wdata = rand_word();
		repeat ($urandom_range(0, 3)) @(negedge clk_esram);
	endtask

	initial begin
		int                i;
		int                n_idle;
		logic [AWIDTH-1:0] a;
		logic [WORD_W-1:0] w;
		void'($urandom(SEED));
		clk_esram   = 1'b0;
		arst_n      = 1'b0;
		req         = 1'b0;
		op          = op_write;
		addr        = '0;
		wdata       = '0;
		err_data    = 0;
		err_hs      = 0;
		err_timeout = 0;
		hung        = 1'b0;
		repeat (4) @(posedge clk_esram);
		@(negedge clk_esram);
		arst_n = 1'b1;

		n_idle = $urandom_range(4, 12);  // ack quiet until the first req
		repeat (n_idle) begin
			@(negedge clk_esram);
			check_ack(1'b0, ack, "ack before first req");
		end

		// directed write and read back, ends of the address range
		run_cmd(op_write, '0, {WORD_W{1'b1}});
		run_cmd(op_read, '0, '0);
		run_cmd(op_write, {AWIDTH{1'b1}}, {16'ha5c3, {(WORD_W-16){1'b0}}});  // top slice only
		run_cmd(op_read, {AWIDTH{1'b1}}, '0);
		for (i = 0; i < 4 && !hung; i++) begin
			a = AWIDTH'($urandom_range(0, 2**AWIDTH - 1));
			w = rand_word();
			run_cmd(op_write, a, w);
			run_cmd(op_read, a, '0);
		end

		// long random mix, reads only where the model holds a word
		for (i = 0; i < NUM_CMDS && !hung; i++) begin
			if (addr_list.size() == 0 || $urandom_range(0, 1) == 0) begin
				a = AWIDTH'($urandom_range(0, 2**AWIDTH - 1));
				run_cmd(op_write, a, rand_word());
			end else begin
				a = AWIDTH'(addr_list[$urandom_range(0, addr_list.size() - 1)]);
				run_cmd(op_read, a, rand_word());  // wdata is ignored on a read
			end
		end

		$display("errors: data %0d, handshake %0d, timeout %0d", err_data, err_hs, err_timeout);
		if (err_data + err_hs + err_timeout == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
verilog/pktbuf_pkg.sv
verilog/pktbuf_access_if.sv
verilog/cmd_decode.sv
verilog/esram_channel.sv
verilog/esram_wrapper.sv
verilog/rd_result.sv
verilog/pktbuf_top.sv
bench/tb_pktbuf.sv

/* Makefile */
# Verilator flow for the packet buffer

TOP := tb_pktbuf

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
